//--- common/mem_pkg.sv
// Host-side definitions shared by the front end and the command engine.
// Covers the request bundle, the host word and address layout and the
// fixed read latency the front end counts against.
package mem_pkg;

    typedef logic [22:0] mem_addr_t;    // one host word per address
    typedef logic [31:0] mem_data_t;
    typedef logic [3:0]  mem_mask_t;    // set bit keeps that byte unwritten
    typedef logic [19:0] wr_count_t;

    // host address split
    localparam int ADDR_BANK_LSB = 21;  // bits 22:21
    localparam int ADDR_ROW_LSB  = 10;  // bits 20:10
    localparam int ADDR_COL_LSB  = 0;   // bits 7:0, bits 9:8 unused

    // one host request, strobes plus payload
    typedef struct packed {
        logic      read_a;
        logic      read_b;
        logic      write;
        logic      refresh;
        mem_addr_t addr;
        mem_data_t din;
        mem_mask_t mask;
    } mem_req_t;

    // accept edge to dout update
    // 1 (start) + T_RCD + CAS latency + 1 (capture) with T_RCD = CL = 2
    localparam int READ_LATENCY = 6;

endpackage

//--- common/sdram_pkg.sv
// SDRAM device definitions: address field types, command encoding,
// the command-side pin bundle and the timing constants in clk cycles.
// Commands are encoded as {cs_n, ras_n, cas_n, we_n}.
package sdram_pkg;

    typedef logic [10:0] sdram_row_t;   // multiplexed address bus
    typedef logic [1:0]  sdram_bank_t;
    typedef logic [7:0]  sdram_col_t;

    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_e;

    // field order matches the packed pin vector driven by the engine
    typedef struct packed {
        logic        cke;
        logic        cs_n;
        logic        ras_n;
        logic        cas_n;
        logic        we_n;
        sdram_bank_t ba;
        sdram_row_t  a;
        logic [3:0]  dqm;
    } sdram_pins_t;

    localparam int AP_BIT = 10;         // auto precharge / precharge all

    localparam int T_RCD       = 2;     // active to read or write
    localparam int CAS_LATENCY = 2;
    localparam int T_RC        = 7;     // refresh cycle
    localparam int T_WR_PRE    = 4;     // write recovery plus precharge
    localparam int T_RP        = 2;
    localparam int T_MRD       = 2;

    // write burst mode, op mode, CAS latency 2, sequential, burst length 1
    localparam sdram_row_t MODE_WORD = {1'b0, 1'b0, 2'b00, 3'b010, 1'b0, 3'b000};

endpackage

//--- sdram/sdram_ctrl.sv
`timescale 1ns/1ps
// SDRAM command engine. After reset it runs the power-up sequence, then
// turns each start pulse into ACTIVE + READ/WRITE with auto precharge or
// into one AUTO REFRESH. The device clock is the inverted clk.
module sdram_ctrl #(
    parameter int INIT_CYCLES = 10000               // power-up wait in clk cycles
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  mem_pkg::mem_req_t      req,
    input  mem_pkg::mem_data_t     dq_in,
    output logic                   eng_busy,
    output mem_pkg::mem_data_t     rd_data,
    output logic                   rd_valid,
    output sdram_pkg::sdram_pins_t pins,
    output logic                   sdram_clk,
    output mem_pkg::mem_data_t     dq_out,
    output logic                   dq_oe
);
    import mem_pkg::*;
    import sdram_pkg::*;

    localparam int WAIT_MAX = (INIT_CYCLES > T_RC) ? INIT_CYCLES : T_RC;
    localparam int WAIT_W   = $clog2(WAIT_MAX + 1);

    typedef enum logic [3:0] {
        ST_POWERUP,
        ST_INIT_PRE,
        ST_INIT_REF,
        ST_INIT_MRS,
        ST_IDLE,
        ST_RCD,
        ST_READ_CL,
        ST_WRITE_REC,
        ST_REFRESH
    } state_e;

    state_e            state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              wait_done;
    logic              second_ref;                  // init runs two refreshes
    sdram_cmd_e        cmd;
    sdram_bank_t       ba;
    sdram_row_t        a;
    logic [3:0]        dqm;
    sdram_col_t        col;

    assign wait_done = (wait_cnt == '0);
    assign col       = req.addr[ADDR_COL_LSB +: $bits(sdram_col_t)];

    // start counts as busy so the front end never sees a gap
    assign eng_busy  = start || (state != ST_IDLE);
    assign sdram_clk = ~clk;                        // device samples mid-cycle
    assign pins      = {1'b1, cmd, ba, a, dqm};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= ST_POWERUP;
            wait_cnt   <= WAIT_W'(INIT_CYCLES);
            second_ref <= 1'b0;
            cmd        <= CMD_NOP;
            ba         <= '0;
            a          <= '0;
            dqm        <= '0;
            dq_oe      <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            cmd      <= CMD_NOP;                    // one-cycle commands
            dqm      <= '0;
            dq_oe    <= 1'b0;
            rd_valid <= 1'b0;
            if (!wait_done) begin
                wait_cnt <= wait_cnt - 1'b1;
            end

            case (state)
                ST_POWERUP: begin
                    if (wait_done) begin
                        cmd      <= CMD_PRECHARGE;
                        a        <= sdram_row_t'(1) << AP_BIT;   // all banks
                        wait_cnt <= WAIT_W'(T_RP - 1);
                        state    <= ST_INIT_PRE;
                    end
                end
                ST_INIT_PRE: begin
                    if (wait_done) begin
                        cmd        <= CMD_REFRESH;
                        wait_cnt   <= WAIT_W'(T_RC - 1);
                        second_ref <= 1'b0;
                        state      <= ST_INIT_REF;
                    end
                end
                ST_INIT_REF: begin
                    if (wait_done && !second_ref) begin
                        cmd        <= CMD_REFRESH;
                        wait_cnt   <= WAIT_W'(T_RC - 1);
                        second_ref <= 1'b1;
                    end else if (wait_done) begin
                        cmd      <= CMD_LOAD_MODE;
                        ba       <= '0;
                        a        <= MODE_WORD;
                        wait_cnt <= WAIT_W'(T_MRD - 1);
                        state    <= ST_INIT_MRS;
                    end
                end
                ST_INIT_MRS: begin
                    if (wait_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (start && (req.read_a || req.read_b || req.write)) begin
                        cmd      <= CMD_ACTIVE;
                        ba       <= req.addr[ADDR_BANK_LSB +: $bits(sdram_bank_t)];
                        a        <= req.addr[ADDR_ROW_LSB +: $bits(sdram_row_t)];
                        wait_cnt <= WAIT_W'(T_RCD - 1);
                        state    <= ST_RCD;
                    end else if (start) begin
                        cmd      <= CMD_REFRESH;
                        wait_cnt <= WAIT_W'(T_RC - 1);
                        state    <= ST_REFRESH;
                    end
                end
                ST_RCD: begin
                    if (wait_done) begin
                        a <= sdram_row_t'(col) | (sdram_row_t'(1) << AP_BIT);
                        if (req.write) begin
                            cmd      <= CMD_WRITE;
                            dq_out   <= req.din;
                            dq_oe    <= 1'b1;       // only in the write cycle
                            dqm      <= req.mask;
                            wait_cnt <= WAIT_W'(T_WR_PRE - 1);
                            state    <= ST_WRITE_REC;
                        end else begin
                            cmd      <= CMD_READ;
                            wait_cnt <= WAIT_W'(CAS_LATENCY);  // capture CL+1 edges later
                            state    <= ST_READ_CL;
                        end
                    end
                end
                ST_READ_CL: begin
                    if (wait_done) begin
                        rd_data  <= dq_in;
                        rd_valid <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                ST_WRITE_REC: begin
                    if (wait_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_REFRESH: begin
                    if (wait_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/memory_controller.sv
`timescale 1ns/1ps
// Host-facing front end. Takes one strobe at a time while idle, forwards it
// to the command engine and holds busy until it completes. Keeps a last-read
// word per read port, a sticky fail flag and a completed-write counter.
module memory_controller (
    input  logic               clk,
    input  logic               resetn,
    input  mem_pkg::mem_req_t  req,
    input  logic               eng_busy,
    input  mem_pkg::mem_data_t rd_data,
    input  logic               rd_valid,
    output logic               start,
    output mem_pkg::mem_req_t  eng_req,
    output mem_pkg::mem_data_t dout_a,
    output mem_pkg::mem_data_t dout_b,
    output logic               busy,
    output logic               mem_initialized,
    output logic               fail,
    output mem_pkg::wr_count_t total_written
);
    import mem_pkg::*;

    localparam int LAT_W = $clog2(READ_LATENCY + 1);

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_REFRESH
    } state_e;

    state_e           state;
    logic [LAT_W-1:0] lat_cnt;                      // cycles since accept
    logic             port_a;
    logic             port_b;
    logic             rd_seen;                      // rd_valid seen for this read
    logic             rd_check;
    logic             any_strobe;
    mem_req_t         next_req;
    mem_data_t        da;
    mem_data_t        db;

    assign any_strobe = req.read_a || req.read_b || req.write || req.refresh;

    // read beats write, write beats refresh
    always_comb begin
        next_req = req;
        if (req.read_a || req.read_b) begin
            next_req.write   = 1'b0;
            next_req.refresh = 1'b0;
        end else if (req.write) begin
            next_req.refresh = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state           <= ST_INIT;
            mem_initialized <= 1'b0;
            fail            <= 1'b0;
            total_written   <= '0;
            start           <= 1'b0;
            lat_cnt         <= '0;
            port_a          <= 1'b0;
            port_b          <= 1'b0;
            rd_seen         <= 1'b0;
            rd_check        <= 1'b0;
        end else begin
            start    <= 1'b0;
            rd_check <= 1'b0;
            rd_seen  <= rd_seen || rd_valid;
            // engine data lands on the completion edge, so check one edge later
            if (rd_check && !(rd_seen || rd_valid)) begin
                fail <= 1'b1;
            end

            case (state)
                ST_INIT: begin
                    if (!eng_busy) begin
                        mem_initialized <= 1'b1;
                        state           <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (any_strobe) begin
                        start   <= 1'b1;
                        eng_req <= next_req;
                        port_a  <= next_req.read_a;
                        port_b  <= next_req.read_b;
                        lat_cnt <= LAT_W'(1);
                        rd_seen <= 1'b0;
                        if (next_req.read_a || next_req.read_b) begin
                            state <= ST_READ;
                        end else if (next_req.write) begin
                            state <= ST_WRITE;
                        end else begin
                            state <= ST_REFRESH;
                        end
                    end
                end
                ST_READ: begin
                    lat_cnt <= lat_cnt + 1'b1;
                    if (lat_cnt == LAT_W'(READ_LATENCY)) begin
                        rd_check <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    if (!eng_busy) begin
                        total_written <= total_written + 1'b1;
                        state         <= ST_IDLE;
                    end
                end
                ST_REFRESH: begin
                    if (!eng_busy) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // each port keeps its last word, only its own reads replace it
    always_ff @(posedge clk) begin
        if (rd_valid && port_a) begin
            da <= rd_data;
        end
        if (rd_valid && port_b) begin
            db <= rd_data;
        end
    end

    assign dout_a = (rd_valid && port_a) ? rd_data : da;   // bypass on capture cycle
    assign dout_b = (rd_valid && port_b) ? rd_data : db;
    assign busy   = (state != ST_IDLE);

endmodule

//--- logic/mem_subsystem.sv
`timescale 1ns/1ps
// Top level of the SDRAM subsystem: host front end plus command engine.
// The DQ tristate is left to a board wrapper via dq_out, dq_oe and dq_in.
module mem_subsystem #(
    parameter int INIT_CYCLES = 10000
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  mem_pkg::mem_req_t      req,
    input  mem_pkg::mem_data_t     dq_in,
    output mem_pkg::mem_data_t     dout_a,
    output mem_pkg::mem_data_t     dout_b,
    output logic                   busy,
    output logic                   mem_initialized,
    output logic                   fail,
    output mem_pkg::wr_count_t     total_written,
    output sdram_pkg::sdram_pins_t pins,
    output logic                   sdram_clk,
    output mem_pkg::mem_data_t     dq_out,
    output logic                   dq_oe
);
    import mem_pkg::*;

    logic      start;
    mem_req_t  eng_req;
    logic      eng_busy;
    mem_data_t rd_data;
    logic      rd_valid;

    memory_controller u_memory_controller (
        .clk             (clk),
        .resetn          (resetn),
        .req             (req),
        .eng_busy        (eng_busy),
        .rd_data         (rd_data),
        .rd_valid        (rd_valid),
        .start           (start),
        .eng_req         (eng_req),
        .dout_a          (dout_a),
        .dout_b          (dout_b),
        .busy            (busy),
        .mem_initialized (mem_initialized),
        .fail            (fail),
        .total_written   (total_written)
    );

    sdram_ctrl #(
        .INIT_CYCLES (INIT_CYCLES)
    ) u_sdram_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .req       (eng_req),
        .dq_in     (dq_in),
        .eng_busy  (eng_busy),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .pins      (pins),
        .sdram_clk (sdram_clk),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
// Testbench clock and reset: 20 ns clock, resetn held low for 5 cycles.
module tb_clock_gen (
    output logic clk,
    output logic resetn
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (5) @(posedge clk);
        #2 resetn = 1'b1;                   // released in the stimulus slot
    end

endmodule

//--- sim/sdram_model.sv
`timescale 1ns/1ps
// Behavioral SDRAM for the testbench. Decodes commands on the rising edge of
// the device clock, keeps one open row per bank, applies dqm on writes and
// drives read data CAS_LATENCY device clocks after READ.
module sdram_model (
    input  logic                   sdram_clk,
    input  sdram_pkg::sdram_pins_t pins,
    input  mem_pkg::mem_data_t     dq_out,
    input  logic                   dq_oe,
    output mem_pkg::mem_data_t     dq_in
);
    import mem_pkg::*;
    import sdram_pkg::*;

    mem_data_t   mem [logic [20:0]];        // sparse, indexed {bank, row, col}
    sdram_row_t  open_row [4];
    logic [3:0]  cmd;
    logic [20:0] word;
    logic [20:0] rd_word;
    int          rd_cnt = 0;
    mem_data_t   rd_q = '0;

    assign cmd   = {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n};
    assign word  = {pins.ba, open_row[pins.ba], pins.a[7:0]};
    assign dq_in = rd_q;

    // words never written read back a pattern of their whole address
    function automatic mem_data_t fetch(input logic [20:0] w);
        if (mem.exists(w)) begin
            return mem[w];
        end
        return {w[10:0], w} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic mem_data_t write_bytes(input mem_data_t old, input mem_data_t din,
                                              input logic [3:0] dqm);
        mem_data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (!dqm[i]) begin
                res[8*i +: 8] = din[8*i +: 8];
            end
        end
        return res;
    endfunction

    always @(posedge sdram_clk) begin
        if (rd_cnt == 1) begin
            rd_q <= fetch(rd_word);
        end
        if (rd_cnt != 0) begin
            rd_cnt <= rd_cnt - 1;
        end
        if (pins.cke) begin
            case (cmd)
                CMD_ACTIVE: begin
                    open_row[pins.ba] <= pins.a;
                end
                CMD_READ: begin
                    rd_word <= word;
                    rd_cnt  <= CAS_LATENCY;
                end
                CMD_WRITE: begin
                    if (dq_oe) begin
                        mem[word] = write_bytes(fetch(word), dq_out, pins.dqm);
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- sim/mem_checker.sv
`timescale 1ns/1ps
// Testbench checker. Watches the host side of the DUT, predicts reads from a
// shadow memory and the port rules, counts writes and REFRESH commands and
// prints one line per test plus a closing summary.
module mem_checker (
    input  logic                   clk,
    input  logic                   resetn,
    input  mem_pkg::mem_req_t      req,
    input  mem_pkg::mem_data_t     dout_a,
    input  mem_pkg::mem_data_t     dout_b,
    input  logic                   busy,
    input  logic                   mem_initialized,
    input  logic                   fail,
    input  mem_pkg::wr_count_t     total_written,
    input  sdram_pkg::sdram_pins_t pins,
    input  int                     test_id,
    input  logic                   test_end,
    input  logic                   finish,
    output int                     error_count
);
    import mem_pkg::*;
    import sdram_pkg::*;

    mem_data_t shadow [mem_addr_t];
    mem_data_t exp_a;
    mem_data_t exp_b;
    mem_data_t rd_expect;
    logic      a_known = 1'b0;
    logic      b_known = 1'b0;
    logic      in_reset = 1'b1;
    logic      is_read;
    logic      rd_a;
    logic      rd_b;
    int        age = 0;                     // edges since accept, 0 when nothing in flight
    int        writes = 0;
    int        refreshes = 0;
    int        refresh_cmds = 0;
    int        reads_checked = 0;
    int        tests = 0;
    int        start_errors = 0;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // a set mask bit keeps the old byte
    function automatic mem_data_t apply_mask(input mem_data_t old, input mem_data_t din,
                                             input mem_mask_t m);
        mem_data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (!m[i]) begin
                res[8*i +: 8] = din[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "initialization";
            2: return "write then read";
            3: return "port holding";
            4: return "refresh";
            5: return "random mix";
            default: return "unnamed";
        endcase
    endfunction

    task automatic step_pending();
        if (age == 1 || (is_read && age <= READ_LATENCY)) begin
            compare("busy", 32'(busy), 32'd1);
        end
        if (is_read && age == READ_LATENCY + 1) begin
            compare("busy", 32'(busy), 32'd0);
            exp_a   = rd_a ? rd_expect : exp_a;
            exp_b   = rd_b ? rd_expect : exp_b;
            a_known = a_known || rd_a;
            b_known = b_known || rd_b;
            reads_checked++;
            age = 0;
        end else if (!is_read && age > 1 && !busy) begin
            age = 0;                        // write or refresh finished
        end else begin
            age++;
        end
    endtask

    // read beats write, write beats refresh
    task automatic accept();
        mem_data_t old;
        age     = 1;
        is_read = req.read_a || req.read_b;
        old     = shadow.exists(req.addr) ? shadow[req.addr] : '0;
        if (is_read) begin
            rd_a      = req.read_a;
            rd_b      = req.read_b;
            rd_expect = old;
        end else if (req.write) begin
            shadow[req.addr] = apply_mask(old, req.din, req.mask);
            writes++;
        end else begin
            refreshes++;
        end
    endtask

    task automatic end_test();
        compare("busy", 32'(busy), 32'd0);
        compare("mem_initialized", 32'(mem_initialized), 32'd1);
        compare("fail", 32'(fail), 32'd0);
        compare("total_written", 32'(total_written), 32'(writes));
        compare("REFRESH commands", 32'(refresh_cmds), 32'(refreshes));
        $display("test %0d %s: %s, %0d errors", test_id, test_name(test_id),
                 (error_count == start_errors) ? "ok" : "failed", error_count - start_errors);
        tests++;
        start_errors = error_count;
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            in_reset    = 1'b1;
            age         = 0;
            error_count = 0;
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                compare("busy", 32'(busy), 32'd1);
                compare("mem_initialized", 32'(mem_initialized), 32'd0);
                compare("fail", 32'(fail), 32'd0);
                compare("total_written", 32'(total_written), 32'd0);
            end
            if ({pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n} == CMD_REFRESH
                    && mem_initialized) begin
                refresh_cmds++;
            end
            if (age != 0) begin
                step_pending();
            end
            if (!busy && (req.read_a || req.read_b || req.write || req.refresh)) begin
                accept();
            end
            if (a_known) begin
                compare("dout_a", dout_a, exp_a);
            end
            if (b_known) begin
                compare("dout_b", dout_b, exp_b);
            end
            if (test_end) begin
                end_test();
            end
            if (finish) begin
                $display("summary: %0d tests, %0d reads checked, %0d writes, %0d refreshes, %0d errors",
                         tests, reads_checked, writes, refreshes,
                         error_count);
            end
        end
    end

endmodule

//--- sim/mem_props.sv
`timescale 1ns/1ps
// Assertions bound into the command engine: command legality on the pins
// and eng_busy while a command is on the bus.
module mem_props (
    input logic                   clk,
    input logic                   resetn,
    input sdram_pkg::sdram_pins_t pins,
    input logic                   dq_oe,
    input logic                   eng_busy
);
    import sdram_pkg::*;

    logic [3:0]  cmd;
    logic        mode_loaded;
    int unsigned since_act;                 // cycles since the last ACTIVE

    assign cmd = {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n};

    always @(posedge clk) begin
        if (!resetn) begin
            mode_loaded <= 1'b0;
            since_act   <= 100;
        end else begin
            if (cmd == CMD_LOAD_MODE) begin
                mode_loaded <= 1'b1;
            end
            if (cmd == CMD_ACTIVE) begin
                since_act <= 1;
            end else if (since_act < 100) begin
                since_act <= since_act + 1;
            end
        end
    end

    no_access_before_mode: assert property (@(posedge clk) disable iff (!resetn)
        (cmd == CMD_ACTIVE || cmd == CMD_READ || cmd == CMD_WRITE) |-> mode_loaded)
        else $error("row or column command before the mode register load");

    trcd_met: assert property (@(posedge clk) disable iff (!resetn)
        (cmd == CMD_READ || cmd == CMD_WRITE) |-> since_act >= T_RCD)
        else $error("READ or WRITE too soon after ACTIVE");

    oe_only_on_write: assert property (@(posedge clk) disable iff (!resetn)
        dq_oe |-> cmd == CMD_WRITE)
        else $error("dq_oe high outside a WRITE cycle");

    busy_during_cmd: assert property (@(posedge clk) disable iff (!resetn)
        cmd != CMD_NOP |-> eng_busy)
        else $error("command on the pins while the engine is idle");

endmodule

//--- sim/tb_mem_subsystem.sv
`timescale 1ns/1ps
// Testbench top for the SDRAM subsystem. Drives host requests made from an
// LFSR, with the SDRAM model on the pins and the checker doing the comparing.
module tb_mem_subsystem;
    import mem_pkg::*;
    import sdram_pkg::*;

    localparam int TIMEOUT = 500;           // cycles allowed per wait
    localparam int NADDR   = 8;

    logic        clk;
    logic        resetn;
    mem_req_t    req;
    mem_data_t   dq_in;
    mem_data_t   dq_out;
    mem_data_t   dout_a;
    mem_data_t   dout_b;
    logic        busy;
    logic        mem_initialized;
    logic        fail;
    logic        sdram_clk;
    logic        dq_oe;
    wr_count_t   total_written;
    sdram_pins_t pins;
    int          errors;
    int          test_id = 0;
    logic        test_end = 1'b0;
    logic        finish = 1'b0;
    logic [31:0] lfsr = 32'h35807b78;
    mem_addr_t   addrs [NADDR];

    tb_clock_gen u_clk_gen (.clk(clk), .resetn(resetn));

    mem_subsystem #(.INIT_CYCLES(20)) UUT (
        .clk(clk), .resetn(resetn), .req(req), .dq_in(dq_in),
        .dout_a(dout_a), .dout_b(dout_b), .busy(busy),
        .mem_initialized(mem_initialized), .fail(fail), .total_written(total_written),
        .pins(pins), .sdram_clk(sdram_clk), .dq_out(dq_out), .dq_oe(dq_oe)
    );

    sdram_model u_sdram (
        .sdram_clk(sdram_clk), .pins(pins), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
    );

    mem_checker u_check (
        .clk(clk), .resetn(resetn), .req(req), .dout_a(dout_a), .dout_b(dout_b),
        .busy(busy), .mem_initialized(mem_initialized), .fail(fail),
        .total_written(total_written), .pins(pins), .test_id(test_id),
        .test_end(test_end), .finish(finish), .error_count(errors)
    );

    bind sdram_ctrl mem_props u_props (
        .clk(clk), .resetn(resetn), .pins(pins), .dq_oe(dq_oe), .eng_busy(eng_busy)
    );

    // x^32 + x^22 + x^2 + x + 1, one new bit per step
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic mem_addr_t rand_addr();
        return {2'(rand_bits(2)), 11'(rand_bits(11)), 2'b00, 8'(rand_bits(8))};
    endfunction

    // strobes are {read_a, read_b, write, refresh}
    function automatic mem_req_t make_req(input logic [3:0] strobes, input mem_addr_t a,
                                          input mem_data_t d, input mem_mask_t m);
        return mem_req_t'({strobes, a, d, m});
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (busy) begin
            abort_run("timeout: busy stayed high while waiting for the DUT to go idle");
        end
    endtask

    task automatic issue(input mem_req_t r);
        wait_idle();
        req = r;
        @(posedge clk);
        #2;
        req = '0;
    endtask

    // a strobe while busy must be ignored by the DUT
    task automatic poke_busy(input mem_req_t r);
        if (busy) begin
            req = r;
            @(posedge clk);
            #2;
            req = '0;
        end
    endtask

    task automatic close_test(input int id);
        wait_idle();
        test_id  = id;
        test_end = 1'b1;
        @(posedge clk);
        #2;
        test_end = 1'b0;
    endtask

    initial begin
        int         n;
        logic [3:0] strobes;
        req = '0;
        n = 0;
        while (!resetn && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!resetn) begin
            abort_run("timeout: reset was never released");
        end
        n = 0;
        while (!mem_initialized && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!mem_initialized) begin
            abort_run("timeout: mem_initialized never rose after reset");
        end
        close_test(1);

        for (int i = 0; i < NADDR; i++) begin
            addrs[i] = rand_addr();
            issue(make_req(4'b0010, addrs[i], rand_bits(32), 4'h0));
        end
        for (int i = 0; i < NADDR; i++) begin
            issue(make_req(4'b0010, addrs[i], rand_bits(32), 4'(rand_bits(4))));
        end
        for (int i = 0; i < NADDR; i++) begin
            issue(make_req(4'b1000, addrs[i], '0, '0));
        end
        close_test(2);

        issue(make_req(4'b1000, addrs[0], '0, '0));
        issue(make_req(4'b0100, addrs[1], '0, '0));
        issue(make_req(4'b1100, addrs[2], '0, '0));
        close_test(3);

        issue(make_req(4'b0001, '0, '0, '0));
        issue(make_req(4'b1000, addrs[3], '0, '0));
        issue(make_req(4'b0100, addrs[3], '0, '0));
        close_test(4);

        for (int i = 0; i < 60; i++) begin
            strobes = 4'(rand_bits(4));
            if (strobes == 4'b0000) begin
                strobes = 4'b0001;
            end
            issue(make_req(strobes, addrs[3'(rand_bits(3))], rand_bits(32), 4'(rand_bits(4))));
            if (rand_bits(1) != 0) begin
                poke_busy(make_req(4'(rand_bits(4)), addrs[3'(rand_bits(3))],
                                   rand_bits(32), 4'h0));
            end
        end
        close_test(5);

        finish = 1'b1;
        @(posedge clk);
        #2;
        finish = 1'b0;
        @(posedge clk);
        #2;
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- mem_subsystem.f
common/mem_pkg.sv
common/sdram_pkg.sv
sdram/sdram_ctrl.sv
logic/memory_controller.sv
logic/mem_subsystem.sv
sim/tb_clock_gen.sv
sim/sdram_model.sv
sim/mem_checker.sv
sim/mem_props.sv
sim/tb_mem_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mem_subsystem \
    -f mem_subsystem.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && exit 1
grep -qF '*** TEST PASSED ***' sim.log || { echo "no result in sim.log"; exit 1; }
exit 0
